//--- files.f
lsu_data_pkg.sv
lsu_bus_pkg.sv
lsu_req_gen.sv
lsu_trans_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

//--- lsu_bus_pkg.sv
package lsu_bus_pkg;

  // Byte lanes of the 32-bit data bus
  parameter int unsigned NUM_LANES = 4;

  // One enable per lane
  typedef logic [NUM_LANES-1:0] be_t;

  // Address phase of one bus transaction
  typedef struct packed {
    lsu_data_pkg::addr_t addr;
    logic                we;
    be_t                 be;
    lsu_data_pkg::data_t wdata;  // already rotated onto its lanes
  } bus_req_t;

  // Response phase, returned in request order
  typedef struct packed {
    lsu_data_pkg::data_t rdata;  // raw word, not realigned
    logic                err;
  } bus_rsp_t;

endpackage

//--- lsu_data_pkg.sv
package lsu_data_pkg;

  // Pipeline side widths
  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Byte position inside a 32-bit word
  typedef logic [1:0] offset_t;

  // Access size as encoded by the execute stage
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  // One load or store as handed over by execute
  typedef struct packed {
    data_t op_a;   // base register
    data_t op_b;   // immediate or index
    data_t wdata;  // store data, lane 0 aligned
    logic  we;
    size_e size;
    logic  sext;
  } lsu_op_t;

  // One result per instruction, valid with its strobe
  typedef struct packed {
    data_t rdata;
    logic  err;
  } lsu_result_t;

endpackage

//--- lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      accept_i,
  input  lsu_data_pkg::lsu_op_t     op_i,
  input  lsu_data_pkg::offset_t     offset_i,
  input  logic                      split_i,
  input  logic                      second_i,
  input  logic                      bus_rvalid_i,
  input  lsu_bus_pkg::bus_rsp_t     bus_rsp_i,
  output logic                      res_valid_o,
  output lsu_data_pkg::lsu_result_t res_o
);

  import lsu_data_pkg::*;

  localparam int unsigned DEPTH = MAX_OUTSTANDING;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  // Per transaction info needed when its response comes back
  typedef struct packed {
    size_e   size;
    logic    sext;
    logic    we;
    offset_t offset;
    logic    second;  // response carries the upper half
    logic    last;    // low only for a first half
  } info_t;

  info_t            info_q [DEPTH];
  info_t            info_wr;
  info_t            head;
  logic [DEPTH-1:0] vld_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             pop;
  data_t            rdata_q;
  logic             err_q;
  logic [63:0]      rdata_full;
  data_t            rdata_shift;
  data_t            rdata_ext;

  //////////////////////////////////////////////////////////////////////////////
  // Info queue
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    info_wr.size   = op_i.size;
    info_wr.sext   = op_i.sext;
    info_wr.we     = op_i.we;
    info_wr.offset = offset_i;
    info_wr.second = second_i;
    info_wr.last   = !split_i;
  end

  assign head = info_q[rd_ptr_q];
  // Responses with an empty queue are ignored here
  assign pop  = bus_rvalid_i && vld_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (accept_i) begin
      info_q[wr_ptr_q] <= info_wr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (pop) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Limit in the controller keeps the write slot free
      if (accept_i) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Realignment and extension
  //////////////////////////////////////////////////////////////////////////////

  // Raw first half kept until its partner arrives
  always_ff @(posedge clk) begin
    if (pop && !head.last) begin
      rdata_q <= bus_rsp_i.rdata;
      err_q   <= bus_rsp_i.err;
    end
  end

  // Doubled word lets a plain shift cover the unsplit case
  assign rdata_full  = head.second ? {bus_rsp_i.rdata, rdata_q}
                                   : {bus_rsp_i.rdata, bus_rsp_i.rdata};
  assign rdata_shift = rdata_full[{head.offset, 3'b000} +: 32];

  always_comb begin
    case (head.size)
      SIZE_BYTE: rdata_ext = {{24{head.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      SIZE_HALF: rdata_ext = {{16{head.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   rdata_ext = rdata_shift;
    endcase
  end

  // One strobe per instruction, on its last response
  assign res_valid_o = pop && head.last;
  // Stores hand back zero
  assign res_o.rdata = head.we ? '0 : rdata_ext;
  // Error of either half
  assign res_o.err   = bus_rsp_i.err || (head.second && err_q);

endmodule

//--- lsu_req_gen.sv
`timescale 1ns/1ps

module lsu_req_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_i,
  input  lsu_data_pkg::lsu_op_t op_i,
  input  logic                  accept_i,
  output lsu_bus_pkg::bus_req_t req_o,
  output lsu_data_pkg::offset_t offset_o,
  output logic                  split_o,
  output logic                  second_o
);

  import lsu_data_pkg::*;
  import lsu_bus_pkg::*;

  addr_t   addr;
  offset_t offset;
  be_t     be;
  data_t   wdata_rot;
  logic    misaligned;
  logic    second_q;

  // Effective address straight from the operands
  assign addr   = op_i.op_a + op_i.op_b;
  assign offset = addr[1:0];

  //////////////////////////////////////////////////////////////////////////////
  // Split detection and phase tracking
  //////////////////////////////////////////////////////////////////////////////

  // Accesses that cross a word boundary
  always_comb begin
    case (op_i.size)
      SIZE_WORD: misaligned = (offset != 2'b00);
      SIZE_HALF: misaligned = (offset == 2'b11);
      default:   misaligned = 1'b0;
    endcase
  end

  // Only the first phase announces a split
  assign split_o = valid_i && !second_q && misaligned;

  // Set when the first half is granted, cleared after the second half
  // Dropped valid also clears it so a killed split cannot leak
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (!valid_i) begin
      second_q <= 1'b0;
    end else if (accept_i) begin
      second_q <= split_o;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (op_i.size)
      SIZE_BYTE: begin
        case (offset)
          2'b00: be = 4'b0001;
          2'b01: be = 4'b0010;
          2'b10: be = 4'b0100;
          2'b11: be = 4'b1000;
        endcase
      end
      SIZE_HALF: begin
        if (second_q) begin
          // Upper byte spills into lane 0 of the next word
          be = 4'b0001;
        end else begin
          case (offset)
            2'b00: be = 4'b0011;
            2'b01: be = 4'b0110;
            2'b10: be = 4'b1100;
            2'b11: be = 4'b1000;
          endcase
        end
      end
      default: begin
        if (second_q) begin
          // Remaining bytes land in the low lanes of the next word
          case (offset)
            2'b00: be = 4'b0000;
            2'b01: be = 4'b0001;
            2'b10: be = 4'b0011;
            2'b11: be = 4'b0111;
          endcase
        end else begin
          case (offset)
            2'b00: be = 4'b1111;
            2'b01: be = 4'b1110;
            2'b10: be = 4'b1100;
            2'b11: be = 4'b1000;
          endcase
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // Store data and request assembly
  //////////////////////////////////////////////////////////////////////////////

  // Rotate left by one lane per offset byte
  // Same rotation serves both halves of a split
  always_comb begin
    case (offset)
      2'b00: wdata_rot = op_i.wdata;
      2'b01: wdata_rot = {op_i.wdata[23:0], op_i.wdata[31:24]};
      2'b10: wdata_rot = {op_i.wdata[15:0], op_i.wdata[31:16]};
      2'b11: wdata_rot = {op_i.wdata[7:0], op_i.wdata[31:8]};
    endcase
  end

  always_comb begin
    // Second phase goes to the next word-aligned address
    req_o.addr  = second_q ? ({addr[31:2], 2'b00} + 32'd4) : addr;
    req_o.we    = op_i.we;
    req_o.be    = be;
    req_o.wdata = wdata_rot;
  end

  assign offset_o = offset;
  assign second_o = second_q;

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Execute stage
  input  logic                      valid_i,
  input  lsu_data_pkg::lsu_op_t     op_i,
  output logic                      ready_o,

  // Data bus
  output logic                      bus_req_o,
  output lsu_bus_pkg::bus_req_t     bus_req_data_o,
  input  logic                      bus_gnt_i,
  input  logic                      bus_rvalid_i,
  input  lsu_bus_pkg::bus_rsp_t     bus_rsp_i,

  // Result, single-cycle strobe
  output logic                      res_valid_o,
  output lsu_data_pkg::lsu_result_t res_o,

  // Status
  output logic                      busy_o,
  output logic                      protocol_err_o
);

  import lsu_data_pkg::*;

  offset_t offset;
  logic    split;
  logic    second;
  logic    accept;

  // Address, lanes and split phase
  lsu_req_gen u_req_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .accept_i (accept),
    .req_o    (bus_req_data_o),
    .offset_o (offset),
    .split_o  (split),
    .second_o (second)
  );

  // Request gating, counter and handshake
  lsu_trans_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_trans_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .split_i        (split),
    .bus_gnt_i      (bus_gnt_i),
    .bus_rvalid_i   (bus_rvalid_i),
    .bus_req_o      (bus_req_o),
    .accept_o       (accept),
    .ready_o        (ready_o),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  // Response side
  lsu_rdata_align #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_i     (accept),
    .op_i         (op_i),
    .offset_i     (offset),
    .split_i      (split),
    .second_i     (second),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rsp_i    (bus_rsp_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o)
  );

endmodule

//--- lsu_trans_ctrl.sv
`timescale 1ns/1ps

module lsu_trans_ctrl #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic split_i,
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  output logic bus_req_o,
  output logic accept_o,
  output logic ready_o,
  output logic busy_o,
  output logic protocol_err_o
);

  // Counter must reach MAX_OUTSTANDING itself
  localparam int unsigned      CNT_W   = $clog2(MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_OUTSTANDING);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;
  logic             count_down;

  //////////////////////////////////////////////////////////////////////////////
  // Request gating and execute handshake
  //////////////////////////////////////////////////////////////////////////////

  // Request follows valid combinationally
  // Held back while the outstanding limit is reached
  assign bus_req_o = valid_i && (cnt_q < CNT_MAX);

  // Address phase done
  assign accept_o = bus_req_o && bus_gnt_i;

  // Execute may move on only after the last phase is granted
  // A first-half grant keeps the instruction in place
  assign ready_o = accept_o && !split_i;

  //////////////////////////////////////////////////////////////////////////////
  // Outstanding transaction counter
  //////////////////////////////////////////////////////////////////////////////

  // Up on grant, down on response
  assign count_up   = accept_o;
  // Stray response must not wrap the counter
  assign count_down = bus_rvalid_i && (cnt_q != '0);

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////////////

  // Open transactions or a request still waiting for grant
  assign busy_o = (cnt_q != '0) || bus_req_o;

  // Response with nothing in flight
  assign protocol_err_o = bus_rvalid_i && (cnt_q == '0);

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  import lsu_data_pkg::*;
  import lsu_bus_pkg::*;

  localparam int unsigned MAX_OUT = 2;
  localparam int unsigned SEED    = 62196;
  // About 70 operations, at most two transactions each, each well below 30 cycles
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  // Expected result, data compared only where it is defined
  typedef struct packed {
    lsu_result_t res;
    logic        chk_data;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        valid;
  lsu_op_t     op;
  logic        ready;
  logic        bus_req;
  bus_req_t    bus_req_data;
  logic        bus_gnt;
  logic        bus_rvalid;
  bus_rsp_t    bus_rsp;
  logic        res_valid;
  lsu_result_t res;
  logic        busy;
  logic        protocol_err;

  logic [7:0]  ref_mem [addr_t];
  exp_t        exp_q [$];
  addr_t       gnt_addr_q [$];
  string       cur_test;
  int          err_cnt      = 0;
  int          err_base     = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          open_cnt     = 0;
  int          gnt_cnt      = 0;
  int          res_cnt      = 0;
  int unsigned cyc_cnt      = 0;

  lsu_top #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .op_i           (op),
    .ready_o        (ready),
    .bus_req_o      (bus_req),
    .bus_req_data_o (bus_req_data),
    .bus_gnt_i      (bus_gnt),
    .bus_rvalid_i   (bus_rvalid),
    .bus_rsp_i      (bus_rsp),
    .res_valid_o    (res_valid),
    .res_o          (res),
    .busy_o         (busy),
    .protocol_err_o (protocol_err)
  );

  tb_lsu_mem u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (bus_req),
    .req_data_i (bus_req_data),
    .gnt_o      (bus_gnt),
    .rvalid_o   (bus_rvalid),
    .rsp_o      (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  initial begin : watchdog
    wait (cyc_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_value(input string what, input data_t exp, input data_t act);
    $display("FAIL %s: %s expected %h, actual %h", cur_test, what, exp, act);
    err_cnt++;
  endtask

  task automatic report_event(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    err_cnt++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt != err_base) begin
      tests_failed++;
      $display("Test %s: %0d errors", cur_test, err_cnt - err_base);
    end else begin
      $display("Test %s: ok", cur_test);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference memory and bus monitor
  ////////////////////////////////////////////////////////////////////////////

  // Same background as the bus memory
  function automatic logic [7:0] ref_byte(input addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  // Byte by byte, little endian, bit 31 marks an erroring byte
  task automatic predict(input lsu_op_t o, output exp_t e);
    addr_t a;
    addr_t b;
    data_t raw;
    int    n;
    a   = o.op_a + o.op_b;
    n   = (o.size == SIZE_BYTE) ? 1 : ((o.size == SIZE_HALF) ? 2 : 4);
    raw = '0;
    e   = '0;
    for (int i = 0; i < n; i++) begin
      b = a + i;
      if (b[31]) begin
        e.res.err = 1'b1;
      end else if (o.we) begin
        ref_mem[b] = o.wdata[8*i +: 8];
      end
      raw[8*i +: 8] = ref_byte(b);
    end
    case (o.size)
      SIZE_BYTE: e.res.rdata = {{24{o.sext & raw[7]}}, raw[7:0]};
      SIZE_HALF: e.res.rdata = {{16{o.sext & raw[15]}}, raw[15:0]};
      default:   e.res.rdata = raw;
    endcase
    if (o.we) begin
      e.res.rdata = '0;
    end
    e.chk_data = o.we || !e.res.err;
  endtask

  always @(posedge clk) begin : bus_monitor
    int   open_nxt;
    exp_t e;
    if (rst_n) begin
      open_nxt = open_cnt;
      if (bus_req && bus_gnt) begin
        open_nxt++;
        gnt_cnt++;
        gnt_addr_q.push_back(bus_req_data.addr);
      end
      if (bus_rvalid) begin
        open_nxt--;
      end
      if (open_nxt > MAX_OUT) begin
        report_event("more than two transactions outstanding");
      end
      open_cnt = open_nxt;
      if (protocol_err) begin
        report_event("protocol error raised");
      end
      if (res_valid) begin
        res_cnt++;
        if (exp_q.size() == 0) begin
          report_event("result strobe with no instruction pending");
        end else begin
          e = exp_q.pop_front();
          if (res.err !== e.res.err) begin
            report_value("err", 32'(e.res.err), 32'(res.err));
          end
          if (e.chk_data && res.rdata !== e.res.rdata) begin
            report_value("rdata", e.res.rdata, res.rdata);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  function automatic lsu_op_t make_op(input addr_t base, input addr_t ofs, input data_t wdata,
                                      input logic we, input size_e size, input logic sext);
    lsu_op_t o;
    o.op_a  = base;
    o.op_b  = ofs;
    o.wdata = wdata;
    o.we    = we;
    o.size  = size;
    o.sext  = sext;
    return o;
  endfunction

  // Hold the op until the last phase is granted, called 1 ns after an edge
  task automatic issue(input lsu_op_t o);
    exp_t e;
    predict(o, e);
    exp_q.push_back(e);
    valid = 1'b1;
    op    = o;
    @(posedge clk);
    while (!ready) begin
      @(posedge clk);
    end
    #1;
    valid = 1'b0;
  endtask

  task automatic wait_results();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Two grants, second at the next aligned word, one strobe
  task automatic check_split(input lsu_op_t o);
    addr_t a;
    int    g0;
    int    r0;
    a  = o.op_a + o.op_b;
    g0 = gnt_cnt;
    r0 = res_cnt;
    gnt_addr_q.delete();
    issue(o);
    wait_results();
    if (gnt_cnt - g0 != 2) begin
      report_value("grant count", 2, gnt_cnt - g0);
    end else begin
      if (gnt_addr_q[0] !== a) begin
        report_value("first address", a, gnt_addr_q[0]);
      end
      if (gnt_addr_q[1] !== ({a[31:2], 2'b00} + 32'd4)) begin
        report_value("second address", {a[31:2], 2'b00} + 32'd4, gnt_addr_q[1]);
      end
    end
    if (res_cnt - r0 != 1) begin
      report_value("result strobes", 1, res_cnt - r0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_word();
    begin_test("reset_word");
    if (res_valid !== 1'b0 || busy !== 1'b0 || protocol_err !== 1'b0) begin
      report_event("status outputs not low after reset");
    end
    if (bus_req !== 1'b0 || ready !== 1'b0) begin
      report_event("request or ready active after reset");
    end
    issue(make_op(32'h0000_0080, 32'h0000_0010, 32'hDEAD_BEEF, 1'b1, SIZE_WORD, 1'b0));
    issue(make_op(32'h0000_0090, 32'h0000_0000, 32'h0, 1'b0, SIZE_WORD, 1'b0));
    wait_results();
    end_test();
  endtask

  // Sign bits differ per byte of the stored word
  task automatic test_narrow_loads();
    begin_test("narrow_loads");
    issue(make_op(32'h0000_0100, 32'h0, 32'h80F7_6A15, 1'b1, SIZE_WORD, 1'b0));
    for (int ofs = 0; ofs < 4; ofs++) begin
      for (int s = 0; s < 2; s++) begin
        issue(make_op(32'h0000_0100, ofs, 32'h0, 1'b0, SIZE_BYTE, 1'(s)));
        issue(make_op(32'h0000_0100, ofs, 32'h0, 1'b0, SIZE_HALF, 1'(s)));
      end
    end
    wait_results();
    end_test();
  endtask

  task automatic test_split();
    begin_test("split");
    for (int ofs = 1; ofs < 4; ofs++) begin
      check_split(make_op(32'h0000_0200 + 16 * ofs, ofs, 32'hC3A5_5A3C + ofs, 1'b1,
                          SIZE_WORD, 1'b0));
      check_split(make_op(32'h0000_0200 + 16 * ofs, ofs, 32'h0, 1'b0, SIZE_WORD, 1'b0));
    end
    check_split(make_op(32'h0000_0238, 32'h3, 32'h0000_9F81, 1'b1, SIZE_HALF, 1'b0));
    check_split(make_op(32'h0000_0238, 32'h3, 32'h0, 1'b0, SIZE_HALF, 1'b1));
    check_split(make_op(32'h0000_0238, 32'h3, 32'h0, 1'b0, SIZE_HALF, 1'b0));
    end_test();
  endtask

  task automatic test_bus_errors();
    begin_test("bus_errors");
    issue(make_op(32'h8000_0000, 32'h10, 32'h0, 1'b0, SIZE_WORD, 1'b0));
    issue(make_op(32'h8000_0000, 32'h20, 32'h1234_5678, 1'b1, SIZE_WORD, 1'b0));
    wait_results();
    // Second half erring, then first half erring with wrap to zero
    check_split(make_op(32'h7FFF_FFF0, 32'h0E, 32'h0, 1'b0, SIZE_WORD, 1'b0));
    check_split(make_op(32'hFFFF_FFF0, 32'h0F, 32'h0, 1'b0, SIZE_HALF, 1'b1));
    // Error must not stick to the next access
    issue(make_op(32'h0000_0100, 32'h0, 32'h0, 1'b0, SIZE_WORD, 1'b0));
    wait_results();
    end_test();
  endtask

  task automatic test_random();
    lsu_op_t o;
    begin_test("random");
    for (int i = 0; i < 30; i++) begin
      o.op_a  = 32'h0000_0300 + ($urandom % 64);
      o.op_b  = $urandom % 8;
      o.wdata = $urandom;
      o.we    = 1'($urandom % 2);
      o.size  = size_e'($urandom % 3);
      o.sext  = 1'($urandom % 2);
      issue(o);
    end
    wait_results();
    if (busy !== 1'b0) begin
      report_event("busy still high after all results arrived");
    end
    if (open_cnt != 0) begin
      report_value("open transactions", 0, open_cnt);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    valid = 1'b0;
    op    = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_reset_word();
    test_narrow_loads();
    test_split();
    test_bus_errors();
    test_random();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb_lsu_mem.sv
`timescale 1ns/1ps

module tb_lsu_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  lsu_bus_pkg::bus_req_t req_data_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output lsu_bus_pkg::bus_rsp_t rsp_o
);

  import lsu_data_pkg::*;
  import lsu_bus_pkg::*;

  // One granted transaction waiting for its response slot
  typedef struct packed {
    bus_rsp_t    rsp;
    logic [31:0] due;
  } pend_t;

  logic [7:0]  mem [addr_t];
  pend_t       pend_q [$];
  logic [1:0]  gnt_wait_q;
  logic [31:0] cyc_q;

  // Unwritten bytes take a value built from every address byte
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic logic [7:0] read_byte(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_byte(a);
  endfunction

  // Grant once the random wait for this request has run out
  assign gnt_o = req_i && (gnt_wait_q == 2'd0);

  always @(posedge clk or negedge rst_n) begin : bus_side
    pend_t p;
    addr_t w;
    addr_t b;
    if (!rst_n) begin
      gnt_wait_q <= 2'd0;
      cyc_q      <= '0;
      rvalid_o   <= 1'b0;
      rsp_o      <= '0;
      pend_q.delete();
    end else begin
      cyc_q <= cyc_q + 1;
      if (req_i && gnt_o) begin
        w           = {req_data_i.addr[31:2], 2'b00};
        p.rsp.err   = req_data_i.addr[31];
        p.rsp.rdata = '0;
        for (int i = 0; i < 4; i++) begin
          b = w + i;
          // Upper half of the address space is unmapped
          if (!p.rsp.err && req_data_i.we && req_data_i.be[i]) begin
            mem[b] = req_data_i.wdata[8*i +: 8];
          end
          if (!req_data_i.we) begin
            p.rsp.rdata[8*i +: 8] = read_byte(b);
          end
        end
        // Response one to three cycles after grant
        p.due = cyc_q + ($urandom % 3);
        pend_q.push_back(p);
        // Wait of 0 to 3 cycles for the next request
        gnt_wait_q <= 2'($urandom % 4);
      end else if (req_i) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      // Strictly in order, at most one response per cycle
      rvalid_o <= 1'b0;
      if (pend_q.size() != 0 && pend_q[0].due <= cyc_q) begin
        rvalid_o <= 1'b1;
        rsp_o    <= pend_q[0].rsp;
        pend_q.pop_front();
      end
    end
  end

endmodule
